// File: design/bypass_pkg.sv
// Stage numbers are 3 bits wide, so a pipeline deeper than 7 stages needs a wider stage_idx_t
package bypass_pkg;

    // Which unit produces the result of an in-flight instruction
    typedef enum logic [1:0] {
        KIND_ALU  = 2'd0,                   // Result ready in EXE
        KIND_LOAD = 2'd1,                   // Result ready in the cache stage
        KIND_MULT = 2'd2                    // Result ready in M5
    } producer_kind_t;

    // Stage number 1..PIPE_DEPTH, also used for wait cycle counts
    typedef logic [2:0] stage_idx_t;

    localparam stage_idx_t STAGE_NONE = 3'd0;   // Register not in flight
    localparam stage_idx_t ALU_STAGE  = 3'd1;   // ALU result ready at EXE

endpackage

// File: design/bypass_top.sv
// Requires 1 < LOAD_STAGE <= MULT_STAGE <= PIPE_DEPTH <= 7, and the outputs have no back-pressure
`timescale 1ns/10ps

module bypass_top #(
    parameter int PIPE_DEPTH = 7,
    parameter int LOAD_STAGE = 3,
    parameter int MULT_STAGE = 6
) (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                issue_valid_i,
    input  bypass_pkg::producer_kind_t          issue_kind_i,
    input  logic                                issue_wr_en_i,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] issue_dst_i,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] issue_src_a_i,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] issue_src_b_i,
    input  logic [core_cfg_pkg::XLEN-1:0]       issue_result_i,
    output logic                                issue_ready_o,
    output logic                                operand_valid_o,
    output logic [core_cfg_pkg::XLEN-1:0]       operand_a_o,
    output logic [core_cfg_pkg::XLEN-1:0]       operand_b_o,
    output logic                                operand_a_fwd_o,
    output logic                                operand_b_fwd_o
);
    import core_cfg_pkg::*;
    import bypass_pkg::*;

    // Pipeline stage view
    logic [PIPE_DEPTH-1:0]                 stage_wr_en;
    logic [PIPE_DEPTH-1:0][REG_ADDR_W-1:0] stage_dst;
    producer_kind_t [PIPE_DEPTH-1:0]       stage_kind;
    logic [PIPE_DEPTH-1:0][XLEN-1:0]       stage_result;

    logic                  retire_en;
    logic [REG_ADDR_W-1:0] retire_dst;
    logic [XLEN-1:0]       retire_data;
    logic [XLEN-1:0]       reg_data_a;
    logic [XLEN-1:0]       reg_data_b;

    logic [XLEN-1:0] byp_operand_a;
    logic [XLEN-1:0] byp_operand_b;
    logic            byp_fwd_a;
    logic            byp_fwd_b;
    logic            hazard;
    stage_idx_t      wait_cycles;

    logic accept;
    logic timer_load;
    logic timer_done;

    reg_file i_reg_file (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .rd_addr_a_i (issue_src_a_i),
        .rd_addr_b_i (issue_src_b_i),
        .rd_data_a_o (reg_data_a),
        .rd_data_b_o (reg_data_b),
        .wr_en_i     (retire_en),
        .wr_addr_i   (retire_dst),
        .wr_data_i   (retire_data)
    );

    // Bubbles enter while stalled since accept stays low
    inflight_pipe #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) i_inflight_pipe (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .push_i         (accept),
        .kind_i         (issue_kind_i),
        .wr_en_i        (issue_wr_en_i),
        .dst_i          (issue_dst_i),
        .result_i       (issue_result_i),
        .stage_wr_en_o  (stage_wr_en),
        .stage_dst_o    (stage_dst),
        .stage_kind_o   (stage_kind),
        .stage_result_o (stage_result),
        .retire_en_o    (retire_en),
        .retire_dst_o   (retire_dst),
        .retire_data_o  (retire_data)
    );

    operand_bypass #(
        .PIPE_DEPTH (PIPE_DEPTH),
        .LOAD_STAGE (LOAD_STAGE),
        .MULT_STAGE (MULT_STAGE)
    ) i_operand_bypass (
        .src_a_i        (issue_src_a_i),
        .src_b_i        (issue_src_b_i),
        .stage_wr_en_i  (stage_wr_en),
        .stage_dst_i    (stage_dst),
        .stage_kind_i   (stage_kind),
        .stage_result_i (stage_result),
        .reg_data_a_i   (reg_data_a),
        .reg_data_b_i   (reg_data_b),
        .operand_a_o    (byp_operand_a),
        .operand_b_o    (byp_operand_b),
        .fwd_a_o        (byp_fwd_a),
        .fwd_b_o        (byp_fwd_b),
        .hazard_o       (hazard),
        .wait_cycles_o  (wait_cycles)
    );

    stall_timer #(
        .PIPE_DEPTH (PIPE_DEPTH)
    ) i_stall_timer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .load_i       (timer_load),
        .load_value_i (wait_cycles),
        .done_o       (timer_done)
    );

    issue_fsm i_issue_fsm (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .issue_valid_i (issue_valid_i),
        .hazard_i      (hazard),
        .timer_done_i  (timer_done),
        .issue_ready_o (issue_ready_o),
        .accept_o      (accept),
        .timer_load_o  (timer_load)
    );

    // Operands appear the cycle after acceptance
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            operand_valid_o <= 1'b0;
        end else begin
            operand_valid_o <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            operand_a_o     <= byp_operand_a;
            operand_b_o     <= byp_operand_b;
            operand_a_fwd_o <= byp_fwd_a;
            operand_b_fwd_o <= byp_fwd_b;
        end
    end

endmodule

// File: design/core_cfg_pkg.sv
// Core widths are fixed for a 32-bit integer core with 32 registers, and register 0 always reads zero
package core_cfg_pkg;

    // Operand and result width of every execute unit
    localparam int XLEN = 32;

    // Register file addressing
    localparam int REG_ADDR_W = 5;          // Enough for NUM_REGS entries
    localparam int NUM_REGS   = 32;         // Entry 0 is hardwired to zero

endpackage

// File: design/inflight_pipe.sv
// Shifts every cycle with no stall input, and PIPE_DEPTH must be at least 2
`timescale 1ns/10ps

module inflight_pipe #(
    parameter int PIPE_DEPTH = 7
) (
    input  logic                                                  clk_i,
    input  logic                                                  reset_i,
    input  logic                                                  push_i,
    input  bypass_pkg::producer_kind_t                            kind_i,
    input  logic                                                  wr_en_i,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0]                   dst_i,
    input  logic [core_cfg_pkg::XLEN-1:0]                         result_i,
    output logic [PIPE_DEPTH-1:0]                                 stage_wr_en_o,
    output logic [PIPE_DEPTH-1:0][core_cfg_pkg::REG_ADDR_W-1:0]   stage_dst_o,
    output bypass_pkg::producer_kind_t [PIPE_DEPTH-1:0]           stage_kind_o,
    output logic [PIPE_DEPTH-1:0][core_cfg_pkg::XLEN-1:0]         stage_result_o,
    output logic                                                  retire_en_o,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0]                   retire_dst_o,
    output logic [core_cfg_pkg::XLEN-1:0]                         retire_data_o
);
    import core_cfg_pkg::*;
    import bypass_pkg::*;

    // Entry 0 holds stage 1 (EXE), entry PIPE_DEPTH-1 holds writeback
    logic [PIPE_DEPTH-1:0]                 wr_en_q;
    logic [PIPE_DEPTH-1:0][REG_ADDR_W-1:0] dst_q;
    producer_kind_t [PIPE_DEPTH-1:0]       kind_q;
    logic [PIPE_DEPTH-1:0][XLEN-1:0]       result_q;

    // A cycle without push shifts in a bubble
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_en_q <= '0;
        end else begin
            wr_en_q <= {wr_en_q[PIPE_DEPTH-2:0], push_i & wr_en_i};
        end
    end

    // Payload follows the write enable, and is ignored once that is clear
    always_ff @(posedge clk_i) begin
        for (int s = PIPE_DEPTH - 1; s > 0; s--) begin
            dst_q[s]    <= dst_q[s-1];
            kind_q[s]   <= kind_q[s-1];
            result_q[s] <= result_q[s-1];
        end
        dst_q[0]    <= dst_i;
        kind_q[0]   <= kind_i;
        result_q[0] <= result_i;
    end

    assign stage_wr_en_o  = wr_en_q;
    assign stage_dst_o    = dst_q;
    assign stage_kind_o   = kind_q;
    assign stage_result_o = result_q;

    // Last stage writes the register file on the edge it leaves
    assign retire_en_o   = wr_en_q[PIPE_DEPTH-1];
    assign retire_dst_o  = dst_q[PIPE_DEPTH-1];
    assign retire_data_o = result_q[PIPE_DEPTH-1];

endmodule

// File: design/issue_fsm.sv
// Decode must hold the issue signals stable while stalled, as ready is low for the whole stall
`timescale 1ns/10ps

module issue_fsm (
    input  logic clk_i,
    input  logic reset_i,
    input  logic issue_valid_i,
    input  logic hazard_i,
    input  logic timer_done_i,
    output logic issue_ready_o,
    output logic accept_o,
    output logic timer_load_o
);
    typedef enum logic {
        ST_RUN   = 1'b0,
        ST_STALL = 1'b1
    } state_t;

    state_t state_q;
    state_t state_d;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ST_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // A one-cycle wait is covered by the hazard cycle alone and stays in RUN
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_RUN: begin
                if (timer_load_o && !timer_done_i) begin
                    state_d = ST_STALL;
                end
            end
            ST_STALL: begin
                if (timer_done_i) begin
                    state_d = ST_RUN;
                end
            end
            default: state_d = ST_RUN;
        endcase
    end

    assign issue_ready_o = (state_q == ST_RUN) && !(issue_valid_i && hazard_i);
    assign accept_o      = issue_valid_i && issue_ready_o;
    assign timer_load_o  = (state_q == ST_RUN) && issue_valid_i && hazard_i;  // First hazard cycle

endmodule

// File: design/operand_bypass.sv
// Requires 1 < LOAD_STAGE <= MULT_STAGE <= PIPE_DEPTH, and only the newest producer of a source counts
`timescale 1ns/10ps

module operand_bypass #(
    parameter int PIPE_DEPTH = 7,
    parameter int LOAD_STAGE = 3,
    parameter int MULT_STAGE = 6
) (
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0]                   src_a_i,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0]                   src_b_i,
    input  logic [PIPE_DEPTH-1:0]                                 stage_wr_en_i,
    input  logic [PIPE_DEPTH-1:0][core_cfg_pkg::REG_ADDR_W-1:0]   stage_dst_i,
    input  bypass_pkg::producer_kind_t [PIPE_DEPTH-1:0]           stage_kind_i,
    input  logic [PIPE_DEPTH-1:0][core_cfg_pkg::XLEN-1:0]         stage_result_i,
    input  logic [core_cfg_pkg::XLEN-1:0]                         reg_data_a_i,
    input  logic [core_cfg_pkg::XLEN-1:0]                         reg_data_b_i,
    output logic [core_cfg_pkg::XLEN-1:0]                         operand_a_o,
    output logic [core_cfg_pkg::XLEN-1:0]                         operand_b_o,
    output logic                                                  fwd_a_o,
    output logic                                                  fwd_b_o,
    output logic                                                  hazard_o,
    output bypass_pkg::stage_idx_t                                wait_cycles_o
);
    import core_cfg_pkg::*;
    import bypass_pkg::*;

    localparam stage_idx_t LOAD_READY = stage_idx_t'(LOAD_STAGE);
    localparam stage_idx_t MULT_READY = stage_idx_t'(MULT_STAGE);

    // Index 0 is source A, index 1 is source B
    logic [1:0][REG_ADDR_W-1:0] src;
    logic [1:0][XLEN-1:0]       reg_data;
    logic [1:0][XLEN-1:0]       operand;
    logic [1:0]                 fwd;
    stage_idx_t                 hit_stage  [2];
    stage_idx_t                 need_stage [2];
    stage_idx_t                 wait_src   [2];

    // Earliest stage at which a producer's result may be forwarded
    function automatic stage_idx_t ready_stage(input producer_kind_t kind);
        case (kind)
            KIND_LOAD: return LOAD_READY;
            KIND_MULT: return MULT_READY;
            default:   return ALU_STAGE;
        endcase
    endfunction

    assign src      = {src_b_i, src_a_i};
    assign reg_data = {reg_data_b_i, reg_data_a_i};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hit_stage[i]  = STAGE_NONE;
            need_stage[i] = ALU_STAGE;
            wait_src[i]   = '0;
            fwd[i]        = 1'b0;
            operand[i]    = reg_data[i];

            // Oldest to newest, so the lowest matching stage is kept
            for (int s = PIPE_DEPTH; s >= 1; s--) begin
                if ((src[i] != '0) && stage_wr_en_i[s-1] && (stage_dst_i[s-1] == src[i])) begin
                    hit_stage[i] = stage_idx_t'(s);
                end
            end

            if (hit_stage[i] != STAGE_NONE) begin
                need_stage[i] = ready_stage(stage_kind_i[hit_stage[i]-1]);
                if (hit_stage[i] >= need_stage[i]) begin
                    fwd[i]     = 1'b1;
                    operand[i] = stage_result_i[hit_stage[i]-1];
                end else begin
                    wait_src[i] = need_stage[i] - hit_stage[i];  // Cycles until it reaches need_stage
                end
            end
        end
    end

    assign operand_a_o = operand[0];
    assign operand_b_o = operand[1];
    assign fwd_a_o     = fwd[0];
    assign fwd_b_o     = fwd[1];

    assign hazard_o      = (wait_src[0] != '0) || (wait_src[1] != '0);
    assign wait_cycles_o = (wait_src[0] > wait_src[1]) ? wait_src[0] : wait_src[1];

endmodule

// File: design/reg_file.sv
// Two combinational read ports and one synchronous write port; writes to register 0 are dropped
`timescale 1ns/10ps

module reg_file (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_addr_a_i,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_addr_b_i,
    output logic [core_cfg_pkg::XLEN-1:0]       rd_data_a_o,
    output logic [core_cfg_pkg::XLEN-1:0]       rd_data_b_o,
    input  logic                                wr_en_i,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [core_cfg_pkg::XLEN-1:0]       wr_data_i
);
    import core_cfg_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // Register 0 is cleared by reset and never written
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    assign rd_data_a_o = regs[rd_addr_a_i];     // Same-cycle read, no internal bypass
    assign rd_data_b_o = regs[rd_addr_b_i];

endmodule

// File: design/stall_timer.sv
// Keeps load_value_i minus one after a load, and done_o looks ahead at load_value_i during the load cycle
`timescale 1ns/10ps

module stall_timer #(
    parameter int PIPE_DEPTH = 7
) (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   load_i,
    input  bypass_pkg::stage_idx_t load_value_i,
    output logic                   done_o
);
    localparam int CNT_W = $clog2(PIPE_DEPTH + 1);

    logic [CNT_W-1:0] count_q;

    // The load cycle is itself the first stall cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= (load_value_i == '0) ? '0 : CNT_W'(load_value_i - 1'b1);
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;      // Holds at zero
        end
    end

    // High in the last stall cycle, so issue resumes on the following edge
    assign done_o = load_i ? (load_value_i <= 3'd1) : (count_q <= CNT_W'(1));

endmodule

// File: list.f
design/core_cfg_pkg.sv
design/bypass_pkg.sv
design/reg_file.sv
design/inflight_pipe.sv
design/operand_bypass.sv
design/stall_timer.sv
design/issue_fsm.sv
design/bypass_top.sv
verif/tb_clock_gen.sv
verif/bypass_assertions.sv
verif/bypass_tb.sv

// File: verif/bypass_assertions.sv
// Bound into issue_fsm and assumes its parent is bypass_top, as operand_valid_o is read there
`timescale 1ns/10ps

module issue_fsm_assertions (
    input logic clk_i,
    input logic reset_i,
    input logic issue_valid_i,
    input logic hazard_i,
    input logic issue_ready_i,
    input logic accept_i,
    input logic stalled_i,
    input logic operand_valid_i
);
    int fail_count = 0;                     // Watched by the testbench

    ready_drop_has_hazard: assert property (@(posedge clk_i) disable iff (reset_i)
        $fell(issue_ready_i) |-> (issue_valid_i && hazard_i))
        else begin
            fail_count++;
            $error("issue_ready_o dropped without a hazard");
        end

    accept_gives_operands: assert property (@(posedge clk_i) disable iff (reset_i)
        accept_i |=> operand_valid_i)
        else begin
            fail_count++;
            $error("operand_valid_o missing after an acceptance");
        end

    no_accept_in_stall: assert property (@(posedge clk_i) disable iff (reset_i)
        stalled_i |-> !accept_i)
        else begin
            fail_count++;
            $error("Instruction accepted in STALL");
        end

endmodule

bind issue_fsm issue_fsm_assertions i_issue_fsm_assertions (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .issue_valid_i   (issue_valid_i),
    .hazard_i        (hazard_i),
    .issue_ready_i   (issue_ready_o),
    .accept_i        (accept_o),
    .stalled_i       (state_q == ST_STALL),
    .operand_valid_i (bypass_top.operand_valid_o)
);

// File: verif/bypass_tb.sv
// Covers the default configuration only (7 stages, load at 3, mult at 6), stops at the first error
`timescale 1ns/10ps

module bypass_tb;
    import core_cfg_pkg::*;
    import bypass_pkg::*;

    localparam int PIPE_DEPTH = 7;
    localparam int LOAD_STAGE = 3;
    localparam int MULT_STAGE = 6;
    localparam int WAIT_LIMIT = 20;         // Edges before any wait gives up

    typedef struct packed {
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic            fwd_a;
        logic            fwd_b;
    } expect_t;

    logic clk, reset, issue_valid, issue_wr_en, issue_ready;
    logic operand_valid, operand_a_fwd, operand_b_fwd;
    producer_kind_t        issue_kind;
    logic [REG_ADDR_W-1:0] issue_dst, issue_src_a, issue_src_b;
    logic [XLEN-1:0]       issue_result, operand_a, operand_b;

    logic [XLEN-1:0] model_regs  [NUM_REGS];    // Newest value written to each register
    int              writer_edge [NUM_REGS];    // Acceptance edge of that writer
    producer_kind_t  writer_kind [NUM_REGS];
    expect_t         expect_q [$];
    int              edge_cnt;
    int              checked;
    logic [31:0]     lcg_state;

    tb_clock_gen #(.PERIOD_NS(20.0)) i_clock_gen (.clk_o(clk));

    bypass_top i_dut (
        .clk_i           (clk),
        .reset_i         (reset),
        .issue_valid_i   (issue_valid),
        .issue_kind_i    (issue_kind),
        .issue_wr_en_i   (issue_wr_en),
        .issue_dst_i     (issue_dst),
        .issue_src_a_i   (issue_src_a),
        .issue_src_b_i   (issue_src_b),
        .issue_result_i  (issue_result),
        .issue_ready_o   (issue_ready),
        .operand_valid_o (operand_valid),
        .operand_a_o     (operand_a),
        .operand_b_o     (operand_b),
        .operand_a_fwd_o (operand_a_fwd),
        .operand_b_fwd_o (operand_b_fwd)
    );

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int result_ready_stage(input producer_kind_t kind);
        case (kind)
            KIND_LOAD: return LOAD_STAGE;
            KIND_MULT: return MULT_STAGE;
            default:   return 1;                // ALU result ready in EXE
        endcase
    endfunction

    // Reference view of one source for an instruction seen at edge at_edge
    function automatic void model_source(input logic [REG_ADDR_W-1:0] src, input int at_edge,
                                         output logic [XLEN-1:0] value, output logic fwd,
                                         output int wait_cyc);
        int age;
        age      = at_edge - writer_edge[src];
        value    = model_regs[src];
        fwd      = (src != '0) && (age <= PIPE_DEPTH);   // Still in flight at that edge
        wait_cyc = 0;
        if ((src != '0) && (result_ready_stage(writer_kind[src]) > age)) begin
            wait_cyc = result_ready_stage(writer_kind[src]) - age;
        end
    endfunction

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] want);
        if (got !== want) begin
            fail_now($sformatf("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h",
                               $time, what, got, want));
        end
    endtask

    // Starts and ends on a falling edge, so calls in a row issue back to back
    task automatic send_instr(input producer_kind_t kind, input logic wr_en,
                              input logic [REG_ADDR_W-1:0] dst, input logic [REG_ADDR_W-1:0] src_a,
                              input logic [REG_ADDR_W-1:0] src_b, input logic [XLEN-1:0] result,
                              output int stall);
        int      offer_edge;
        int      wait_a;
        int      wait_b;
        expect_t want;
        issue_valid  = 1'b1;
        issue_kind   = kind;
        issue_wr_en  = wr_en;
        issue_dst    = dst;
        issue_src_a  = src_a;
        issue_src_b  = src_b;
        issue_result = result;
        offer_edge   = edge_cnt + 1;            // First edge that could accept it
        model_source(src_a, offer_edge, want.a, want.fwd_a, wait_a);
        model_source(src_b, offer_edge, want.b, want.fwd_b, wait_b);
        stall = 0;
        forever begin
            @(posedge clk);
            if (issue_ready) break;
            stall++;
            if (stall >= WAIT_LIMIT) fail_now("Timeout: issue_ready_o stayed low too long");
        end
        check_value("stall cycles", stall, (wait_a > wait_b) ? wait_a : wait_b);
        model_source(src_a, offer_edge + stall, want.a, want.fwd_a, wait_a);
        model_source(src_b, offer_edge + stall, want.b, want.fwd_b, wait_b);
        expect_q.push_back(want);
        if (wr_en && (dst != '0)) begin
            model_regs[dst]  = result;
            writer_edge[dst] = offer_edge + stall;
            writer_kind[dst] = kind;
        end
        @(negedge clk);
    endtask

    task automatic idle(input int cycles);
        issue_valid = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    always @(negedge clk) begin : compare_operands
        expect_t want;
        if (!reset && operand_valid) begin
            if (expect_q.size() == 0) fail_now("operand_valid_o high with nothing accepted");
            want = expect_q.pop_front();
            check_value("operand_a_o", operand_a, want.a);
            check_value("operand_b_o", operand_b, want.b);
            check_value("operand_a_fwd_o", operand_a_fwd, want.fwd_a);
            check_value("operand_b_fwd_o", operand_b_fwd, want.fwd_b);
            checked++;
        end
    end

    // Bound assertions on issue_fsm stop the run half a cycle after they fire
    always @(negedge clk) begin : watch_assertions
        if (i_dut.i_issue_fsm.i_issue_fsm_assertions.fail_count != 0) begin
            fail_now("A bound assertion on issue_fsm failed");
        end
    end

    initial begin
        int          stall;
        int          edges;
        logic [31:0] r;
        lcg_state = 32'd32293;
        edge_cnt  = 0;
        checked   = 0;
        reset     = 1'b1;
        issue_valid  = 1'b0;
        issue_kind   = KIND_ALU;
        issue_wr_en  = 1'b0;
        issue_dst    = '0;
        issue_src_a  = '0;
        issue_src_b  = '0;
        issue_result = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i]  = '0;
            writer_edge[i] = -1000;             // Long retired
            writer_kind[i] = KIND_ALU;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;
        check_value("issue_ready_o after reset", issue_ready, 1);

        for (int i = 0; i < NUM_REGS; i += 2) begin
            send_instr(KIND_ALU, 1'b0, 5'd0, REG_ADDR_W'(i), REG_ADDR_W'(i + 1), 32'h0, stall);
        end
        send_instr(KIND_ALU, 1'b1, 5'd0, 5'd0, 5'd0, 32'hdead_beef, stall);
        send_instr(KIND_ALU, 1'b0, 5'd1, 5'd0, 5'd0, 32'h0, stall);
        idle(PIPE_DEPTH + 2);
        send_instr(KIND_ALU, 1'b0, 5'd1, 5'd0, 5'd0, 32'h0, stall);

        // Dependent ALU chain
        send_instr(KIND_ALU, 1'b1, 5'd1, 5'd0, 5'd0, 32'h1111_0001, stall);
        send_instr(KIND_ALU, 1'b1, 5'd1, 5'd1, 5'd0, 32'h1111_0002, stall);
        send_instr(KIND_ALU, 1'b1, 5'd2, 5'd1, 5'd1, 32'h2222_0003, stall);
        check_value("ALU chain stall", stall, 0);

        send_instr(KIND_LOAD, 1'b1, 5'd3, 5'd0, 5'd0, 32'h3333_0000, stall);
        send_instr(KIND_ALU, 1'b1, 5'd4, 5'd3, 5'd2, 32'h4444_0000, stall);
        check_value("load-use stall", stall, LOAD_STAGE - 1);
        send_instr(KIND_MULT, 1'b1, 5'd5, 5'd3, 5'd4, 32'h5555_0000, stall);
        send_instr(KIND_ALU, 1'b0, 5'd0, 5'd6, 5'd7, 32'h0, stall);
        send_instr(KIND_ALU, 1'b1, 5'd6, 5'd0, 5'd5, 32'h6666_0000, stall);
        check_value("mult-use stall", stall, MULT_STAGE - 2);

        // Older ready ALU, newer unready mult on the same register
        send_instr(KIND_ALU, 1'b1, 5'd7, 5'd0, 5'd0, 32'h7777_0001, stall);
        send_instr(KIND_MULT, 1'b1, 5'd7, 5'd0, 5'd0, 32'h7777_0002, stall);
        send_instr(KIND_ALU, 1'b1, 5'd8, 5'd7, 5'd0, 32'h8888_0000, stall);
        check_value("newest producer stall", stall, MULT_STAGE - 1);

        // Ages PIPE_DEPTH and PIPE_DEPTH+1 around writeback
        send_instr(KIND_ALU, 1'b1, 5'd9, 5'd0, 5'd0, 32'h9999_0000, stall);
        idle(PIPE_DEPTH - 1);
        send_instr(KIND_ALU, 1'b0, 5'd0, 5'd9, 5'd0, 32'h0, stall);
        send_instr(KIND_ALU, 1'b0, 5'd0, 5'd0, 5'd9, 32'h0, stall);

        for (int n = 0; n < 400; n++) begin
            r = lcg_next();
            send_instr(producer_kind_t'((r[17:16] == 2'd3) ? 2'd0 : r[17:16]), r[20:18] != 3'd0,
                       REG_ADDR_W'(r[23:21]), REG_ADDR_W'(r[26:24]), REG_ADDR_W'(r[29:27]),
                       lcg_next(), stall);
            if (r[15:13] == 3'd0) idle(int'(r[12:11]) + 1);
        end

        idle(0);
        edges = 0;
        while (expect_q.size() != 0) begin
            @(negedge clk);
            edges++;
            if (edges >= WAIT_LIMIT) fail_now("Timeout: accepted instruction gave no operands");
        end
        idle(2);
        $display("Checked %0d operand pairs", checked);
        if (i_dut.i_issue_fsm.i_issue_fsm_assertions.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verif/tb_clock_gen.sv
// Free-running clock from time zero; the first rising edge comes half a period after start
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

endmodule
